/* src/sh_pkg.sv */
package sh_pkg;

	typedef logic [31:0] word_t;
	typedef logic [3:0]  reg_idx_t;
	typedef logic [15:0] instr_t;

	typedef enum logic [3:0] {
		ALU_PASS,
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_CMPEQ,
		ALU_SHLL,
		ALU_SHLR,
		ALU_NONE
	} alu_op_t;

	typedef struct packed {
		alu_op_t  alu_op;
		reg_idx_t rn;
		reg_idx_t rm;
		logic     rn_rd;
		logic     rm_rd;
		logic     rn_we;
		logic     t_we;
		logic     use_imm;
		word_t    imm;
		logic     is_branch;
		logic     br_true;
		word_t    disp;
	} dec_instr_t;

	// Major opcode in bits 15:12
	localparam logic [3:0] OP_LOGIC   = 4'h2;
	localparam logic [3:0] OP_ARITH   = 4'h3;
	localparam logic [3:0] OP_SHIFT   = 4'h4;
	localparam logic [3:0] OP_MOV_RR  = 4'h6;
	localparam logic [3:0] OP_ADD_IMM = 4'h7;
	localparam logic [3:0] OP_BRANCH  = 4'h8;
	localparam logic [3:0] OP_MOV_IMM = 4'hE;

	// Function field in bits 3:0
	localparam logic [3:0] FN_CMPEQ = 4'h0;
	localparam logic [3:0] FN_MOV   = 4'h3;
	localparam logic [3:0] FN_SUB   = 4'h8;
	localparam logic [3:0] FN_AND   = 4'h9;
	localparam logic [3:0] FN_XOR   = 4'hA;
	localparam logic [3:0] FN_OR    = 4'hB;
	localparam logic [3:0] FN_ADD   = 4'hC;

	// Shift selector in bits 7:0, branch selector in bits 11:8
	localparam logic [7:0] FN_SHLL = 8'h00;
	localparam logic [7:0] FN_SHLR = 8'h01;
	localparam logic [3:0] BR_BT   = 4'h9;
	localparam logic [3:0] BR_BF   = 4'hB;

	localparam instr_t NOP_INSTR = 16'h0009;

	localparam dec_instr_t DEC_NOP = '{alu_op: ALU_NONE, default: '0};

endpackage

/* src/sh_fetch.sv */
module sh_fetch
	import sh_pkg::*;
#(
	parameter word_t RESET_PC = 32'h0000_0000
) (
	input  logic   CLK,
	input  logic   RST_N,
	input  logic   en,
	input  instr_t inst_data,
	input  logic   branch_taken,
	input  word_t  branch_target,
	output word_t  inst_addr,
	output instr_t id_instr,
	output word_t  id_pc
);

	word_t pc;

	//******************************
	// Program counter and IF/ID
	//******************************
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			pc       <= RESET_PC;
			id_instr <= NOP_INSTR;
		end else if (en) begin
			if (branch_taken) begin
				pc       <= branch_target;
				// Word fetched behind the branch is dropped
				id_instr <= NOP_INSTR;
			end else begin
				pc       <= pc + 32'd2;
				id_instr <= inst_data;
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (en) begin
			id_pc <= pc;
		end
	end

	assign inst_addr = pc;

endmodule

/* src/sh_decode.sv */
module sh_decode
	import sh_pkg::*;
(
	input  logic       CLK,
	input  logic       RST_N,
	input  logic       en,
	input  instr_t     id_instr,
	input  word_t      id_pc,
	input  logic       branch_taken,
	input  word_t      rn_val,
	input  word_t      rm_val,
	output reg_idx_t   rd_rn,
	output reg_idx_t   rd_rm,
	output dec_instr_t ex_dec,
	output word_t      ex_pc,
	output word_t      ex_rn_val,
	output word_t      ex_rm_val
);

	dec_instr_t dec;

	assign rd_rn = id_instr[11:8];
	assign rd_rm = id_instr[7:4];

	//******************************
	// Instruction decoder
	//******************************
	always_comb begin
		dec      = DEC_NOP;
		dec.rn   = id_instr[11:8];
		dec.rm   = id_instr[7:4];
		dec.imm  = {{24{id_instr[7]}}, id_instr[7:0]};
		dec.disp = {{24{id_instr[7]}}, id_instr[7:0]};

		case (id_instr[15:12])
			OP_MOV_IMM: begin
				dec.alu_op  = ALU_PASS;
				dec.use_imm = 1'b1;
				dec.rn_we   = 1'b1;
			end
			OP_ADD_IMM: begin
				dec.alu_op  = ALU_ADD;
				dec.use_imm = 1'b1;
				dec.rn_rd   = 1'b1;
				dec.rn_we   = 1'b1;
			end
			OP_MOV_RR: begin
				if (id_instr[3:0] == FN_MOV) begin
					dec.alu_op = ALU_PASS;
					dec.rm_rd  = 1'b1;
					dec.rn_we  = 1'b1;
				end
			end
			OP_ARITH: begin
				dec.rn_rd = 1'b1;
				dec.rm_rd = 1'b1;
				case (id_instr[3:0])
					FN_ADD: begin
						dec.alu_op = ALU_ADD;
						dec.rn_we  = 1'b1;
					end
					FN_SUB: begin
						dec.alu_op = ALU_SUB;
						dec.rn_we  = 1'b1;
					end
					FN_CMPEQ: begin
						dec.alu_op = ALU_CMPEQ;
						dec.t_we   = 1'b1;
					end
					default: begin
						dec.rn_rd = 1'b0;
						dec.rm_rd = 1'b0;
					end
				endcase
			end
			OP_LOGIC: begin
				dec.rn_rd = 1'b1;
				dec.rm_rd = 1'b1;
				dec.rn_we = 1'b1;
				case (id_instr[3:0])
					FN_AND: dec.alu_op = ALU_AND;
					FN_OR:  dec.alu_op = ALU_OR;
					FN_XOR: dec.alu_op = ALU_XOR;
					default: dec = DEC_NOP;
				endcase
			end
			OP_SHIFT: begin
				if (id_instr[7:0] == FN_SHLL || id_instr[7:0] == FN_SHLR) begin
					dec.alu_op = (id_instr[7:0] == FN_SHLL) ? ALU_SHLL : ALU_SHLR;
					dec.rn_rd  = 1'b1;
					dec.rn_we  = 1'b1;
					dec.t_we   = 1'b1;
				end
			end
			OP_BRANCH: begin
				// BT and BF only, no delay slot
				if (id_instr[11:8] == BR_BT || id_instr[11:8] == BR_BF) begin
					dec.is_branch = 1'b1;
					dec.br_true   = (id_instr[11:8] == BR_BT);
				end
			end
			default: ;
		endcase
	end

	//******************************
	// ID/EX register
	//******************************
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			ex_dec <= DEC_NOP;
		end else if (en) begin
			ex_dec <= branch_taken ? DEC_NOP : dec;
		end
	end

	always_ff @(posedge CLK) begin
		if (en) begin
			ex_pc     <= id_pc;
			ex_rn_val <= rn_val;
			ex_rm_val <= rm_val;
		end
	end

endmodule

/* src/sh_regfile.sv */
module sh_regfile
	import sh_pkg::*;
(
	input  logic     CLK,
	input  logic     RST_N,
	input  logic     en,
	input  reg_idx_t rd_rn,
	input  reg_idx_t rd_rm,
	input  reg_idx_t dbg_regn,
	input  logic     wb_we,
	input  reg_idx_t wb_regn,
	input  word_t    wb_data,
	output word_t    rn_val,
	output word_t    rm_val,
	output word_t    dbg_regq
);

	word_t regs [16];

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			for (int i = 0; i < 16; i++) begin
				regs[i] <= '0;
			end
		end else if (en && wb_we) begin
			regs[wb_regn] <= wb_data;
		end
	end

	// Write-first bypass on the decode ports
	assign rn_val = (wb_we && wb_regn == rd_rn) ? wb_data : regs[rd_rn];
	assign rm_val = (wb_we && wb_regn == rd_rm) ? wb_data : regs[rd_rm];

	assign dbg_regq = regs[dbg_regn];

endmodule

/* src/sh_execute.sv */
module sh_execute
	import sh_pkg::*;
(
	input  logic       CLK,
	input  logic       RST_N,
	input  logic       en,
	input  dec_instr_t ex_dec,
	input  word_t      ex_pc,
	input  word_t      ex_rn_val,
	input  word_t      ex_rm_val,
	output logic       branch_taken,
	output word_t      branch_target,
	output logic       wb_we,
	output reg_idx_t   wb_regn,
	output word_t      wb_data,
	output logic       t_bit
);

	logic  fwd_rn;
	logic  fwd_rm;
	word_t op_a;
	word_t rm_op;
	word_t op_b;
	word_t alu_res;
	logic  alu_t;

	//******************************
	// Operand forwarding
	//******************************
	assign fwd_rn = wb_we && ex_dec.rn_rd && (wb_regn == ex_dec.rn);
	assign fwd_rm = wb_we && ex_dec.rm_rd && (wb_regn == ex_dec.rm);

	assign op_a  = fwd_rn ? wb_data : ex_rn_val;
	assign rm_op = fwd_rm ? wb_data : ex_rm_val;
	assign op_b  = ex_dec.use_imm ? ex_dec.imm : rm_op;

	//******************************
	// ALU
	//******************************
	always_comb begin
		alu_res = '0;
		alu_t   = t_bit;
		case (ex_dec.alu_op)
			ALU_PASS: begin
				alu_res = op_b;
			end
			ALU_ADD: begin
				alu_res = op_a + op_b;
			end
			ALU_SUB: begin
				alu_res = op_a - op_b;
			end
			ALU_AND: begin
				alu_res = op_a & op_b;
			end
			ALU_OR: begin
				alu_res = op_a | op_b;
			end
			ALU_XOR: begin
				alu_res = op_a ^ op_b;
			end
			ALU_CMPEQ: begin
				alu_t = (op_a == op_b);
			end
			ALU_SHLL: begin
				alu_res = {op_a[30:0], 1'b0};
				alu_t   = op_a[31];
			end
			ALU_SHLR: begin
				alu_res = {1'b0, op_a[31:1]};
				alu_t   = op_a[0];
			end
			ALU_NONE: begin
				alu_res = '0;
			end
			default: ;
		endcase
	end

	//******************************
	// Branch resolution
	//******************************
	// BT/BF test the T that is already committed
	assign branch_taken  = ex_dec.is_branch && (t_bit == ex_dec.br_true);
	assign branch_target = ex_pc + 32'd4 + {ex_dec.disp[30:0], 1'b0};

	//******************************
	// T flag and writeback
	//******************************
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			t_bit <= 1'b0;
			wb_we <= 1'b0;
		end else if (en) begin
			if (ex_dec.t_we) begin
				t_bit <= alu_t;
			end
			wb_we <= ex_dec.rn_we;
		end
	end

	always_ff @(posedge CLK) begin
		if (en) begin
			wb_regn <= ex_dec.rn;
			wb_data <= alu_res;
		end
	end

endmodule

/* src/sh_core.sv */
module sh_core
	import sh_pkg::*;
#(
	parameter word_t RESET_PC = 32'h0000_0000
) (
	input  logic     CLK,
	input  logic     RST_N,
	input  logic     en,
	input  instr_t   inst_data,
	input  reg_idx_t dbg_regn,
	output word_t    inst_addr,
	output word_t    dbg_regq,
	output logic     t_bit
);

	instr_t     id_instr;
	word_t      id_pc;
	reg_idx_t   rd_rn;
	reg_idx_t   rd_rm;
	word_t      rn_val;
	word_t      rm_val;
	dec_instr_t ex_dec;
	word_t      ex_pc;
	word_t      ex_rn_val;
	word_t      ex_rm_val;
	logic       branch_taken;
	word_t      branch_target;
	logic       wb_we;
	reg_idx_t   wb_regn;
	word_t      wb_data;

	sh_fetch #(
		.RESET_PC(RESET_PC)
	) i_fetch (
		.CLK          (CLK),
		.RST_N        (RST_N),
		.en           (en),
		.inst_data    (inst_data),
		.branch_taken (branch_taken),
		.branch_target(branch_target),
		.inst_addr    (inst_addr),
		.id_instr     (id_instr),
		.id_pc        (id_pc)
	);

	sh_decode i_decode (
		.CLK         (CLK),
		.RST_N       (RST_N),
		.en          (en),
		.id_instr    (id_instr),
		.id_pc       (id_pc),
		.branch_taken(branch_taken),
		.rn_val      (rn_val),
		.rm_val      (rm_val),
		.rd_rn       (rd_rn),
		.rd_rm       (rd_rm),
		.ex_dec      (ex_dec),
		.ex_pc       (ex_pc),
		.ex_rn_val   (ex_rn_val),
		.ex_rm_val   (ex_rm_val)
	);

	sh_regfile i_regfile (
		.CLK     (CLK),
		.RST_N   (RST_N),
		.en      (en),
		.rd_rn   (rd_rn),
		.rd_rm   (rd_rm),
		.dbg_regn(dbg_regn),
		.wb_we   (wb_we),
		.wb_regn (wb_regn),
		.wb_data (wb_data),
		.rn_val  (rn_val),
		.rm_val  (rm_val),
		.dbg_regq(dbg_regq)
	);

	sh_execute i_execute (
		.CLK          (CLK),
		.RST_N        (RST_N),
		.en           (en),
		.ex_dec       (ex_dec),
		.ex_pc        (ex_pc),
		.ex_rn_val    (ex_rn_val),
		.ex_rm_val    (ex_rm_val),
		.branch_taken (branch_taken),
		.branch_target(branch_target),
		.wb_we        (wb_we),
		.wb_regn      (wb_regn),
		.wb_data      (wb_data),
		.t_bit        (t_bit)
	);

endmodule

/* tests/sh_core_assertions.sv */
module sh_core_assertions
	import sh_pkg::*;
(
	input logic  CLK,
	input logic  RST_N,
	input logic  en,
	input word_t inst_addr,
	input logic  branch_taken,
	input word_t branch_target
);

	int fail_count = 0;

	// Instructions are halfwords
	a_addr_even: assert property (@(posedge CLK) disable iff (!RST_N) !inst_addr[0])
		else begin
			$error("fetch address %h is odd", inst_addr);
			fail_count++;
		end

	a_hold_on_freeze: assert property (@(posedge CLK) disable iff (!RST_N)
		!en |=> $stable(inst_addr))
		else begin
			$error("fetch address moved while en was low");
			fail_count++;
		end

	// Redirect lands on the resolved target
	a_branch_redirect: assert property (@(posedge CLK) disable iff (!RST_N)
		(branch_taken && en) |=> (inst_addr == $past(branch_target)))
		else begin
			$error("fetch address %h is not the branch target", inst_addr);
			fail_count++;
		end

endmodule

bind sh_core sh_core_assertions i_assertions (.*);

/* tests/tb_sh_core.sv */
module tb_sh_core
	import sh_pkg::*;
();

	localparam word_t RESET_PC    = 32'h0000_0100;
	localparam int    CYCLE_LIMIT = 2000;

	logic     CLK;
	logic     RST_N;
	logic     en;
	instr_t   inst_data;
	reg_idx_t dbg_regn;
	word_t    inst_addr;
	word_t    dbg_regq;
	logic     t_bit;

	instr_t prog [64];
	instr_t code [$];
	int     prog_len   = 0;
	word_t  mem_idx;
	int     cycles     = 0;
	int     mismatches = 0;
	int     asserts;
	word_t  exp_regs [16];
	word_t  regs_b [16];

	sh_core #(
		.RESET_PC(RESET_PC)
	) i_sh_core (
		.CLK      (CLK),
		.RST_N    (RST_N),
		.en       (en),
		.inst_data(inst_data),
		.dbg_regn (dbg_regn),
		.inst_addr(inst_addr),
		.dbg_regq (dbg_regq),
		.t_bit    (t_bit)
	);

	// Program memory, NOP past the end
	assign mem_idx   = (inst_addr - RESET_PC) >> 1;
	assign inst_data = (mem_idx < prog_len) ? prog[mem_idx] : 16'h0009;

	initial begin
		CLK = 1'b0;
		forever #10 CLK = ~CLK;
	end

	always @(posedge CLK) begin
		cycles++;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout: tests still running after %0d cycles", CYCLE_LIMIT);
			$display(">>> FAIL");
			$finish;
		end
	end

	//******************************
	// Encoding and helpers
	//******************************
	function automatic instr_t enc_rr(logic [3:0] major, logic [3:0] n, logic [3:0] m,
		logic [3:0] fn);
		return {major, n, m, fn};
	endfunction

	function automatic instr_t enc_ri(logic [3:0] major, logic [3:0] n, logic [7:0] imm);
		return {major, n, imm};
	endfunction

	function automatic word_t sext8(logic [7:0] b);
		return {{24{b[7]}}, b};
	endfunction

	task automatic load_and_reset();
		for (int i = 0; i < 64; i++) begin
			prog[i] = (i < code.size()) ? code[i] : 16'h0009;
		end
		prog_len = code.size();
		@(posedge CLK);
		RST_N <= 1'b0;
		en    <= 1'b0;
		repeat (8) @(posedge CLK);
		RST_N <= 1'b1;
		en    <= 1'b1;
	endtask

	// Last fetch plus four edges puts its result in the register file
	task automatic wait_drain();
		word_t end_addr;
		end_addr = RESET_PC + 2 * (prog_len + 3);
		do @(negedge CLK); while (inst_addr < end_addr);
	endtask

	task automatic read_reg(input reg_idx_t n, output word_t val);
		@(posedge CLK);
		dbg_regn <= n;
		@(negedge CLK);
		val = dbg_regq;
	endtask

	task automatic check_eq(input string name, input word_t exp, input word_t act);
		assert (act === exp) else begin
			mismatches++;
			$display("mismatch %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic check_reg(input string name, input int n, input word_t exp);
		word_t v;
		read_reg(reg_idx_t'(n), v);
		check_eq($sformatf("%s R%0d", name, n), exp, v);
	endtask

	task automatic check_state(input string name, input logic exp_t);
		for (int i = 0; i < 16; i++) begin
			check_reg(name, i, exp_regs[i]);
		end
		check_eq({name, " t"}, word_t'(exp_t), word_t'(t_bit));
	endtask

	//******************************
	// Directed tests
	//******************************
	task automatic test_reset_state();
		code.delete();
		load_and_reset();
		@(negedge CLK);
		check_eq("reset pc", RESET_PC, inst_addr);
		check_eq("reset t", '0, word_t'(t_bit));
		for (int i = 0; i < 16; i++) begin
			check_reg("reset", i, '0);
		end
	endtask

	task automatic test_forwarding();
		logic [7:0] a;
		logic [7:0] b;
		logic [7:0] c;
		word_t      r1;
		word_t      r2;
		a = 8'($urandom);
		b = 8'($urandom);
		c = 8'($urandom);
		code = '{enc_ri(4'hE, 4'd1, a), enc_ri(4'h7, 4'd1, b), enc_ri(4'hE, 4'd2, c),
			enc_rr(4'h3, 4'd2, 4'd1, 4'hC), enc_rr(4'h3, 4'd1, 4'd2, 4'h8),
			enc_rr(4'h3, 4'd1, 4'd1, 4'hC)};
		load_and_reset();
		wait_drain();
		r1 = sext8(a) + sext8(b);
		r2 = sext8(c) + r1;
		r1 = r1 - r2;
		r1 = r1 + r1;
		check_reg("forwarding", 1, r1);
		check_reg("forwarding", 2, r2);
	endtask

	task automatic test_logic_shift();
		logic [7:0] x;
		logic [7:0] y;
		x = 8'($urandom);
		y = 8'($urandom);
		code = '{enc_ri(4'hE, 4'd3, x), enc_ri(4'hE, 4'd4, y),
			enc_rr(4'h6, 4'd5, 4'd3, 4'h3), enc_rr(4'h2, 4'd5, 4'd4, 4'h9),
			enc_rr(4'h6, 4'd6, 4'd3, 4'h3), enc_rr(4'h2, 4'd6, 4'd4, 4'hB),
			enc_rr(4'h6, 4'd7, 4'd3, 4'h3), enc_rr(4'h2, 4'd7, 4'd4, 4'hA),
			enc_rr(4'h6, 4'd9, 4'd4, 4'h3), enc_ri(4'h4, 4'd9, 8'h01),
			enc_rr(4'h6, 4'd8, 4'd3, 4'h3), enc_ri(4'h4, 4'd8, 8'h00)};
		load_and_reset();
		wait_drain();
		check_reg("and", 5, sext8(x) & sext8(y));
		check_reg("or", 6, sext8(x) | sext8(y));
		check_reg("xor", 7, sext8(x) ^ sext8(y));
		check_reg("shlr", 9, sext8(y) >> 1);
		check_reg("shll", 8, sext8(x) << 1);
		// SHLL runs last, T holds its bit 31
		check_eq("shll t", sext8(x) >> 31, word_t'(t_bit));
	endtask

	task automatic test_branches();
		code = '{enc_ri(4'hE, 4'd1, 8'd5), enc_ri(4'hE, 4'd2, 8'd5), enc_ri(4'hE, 4'd3, 8'd7),
			enc_rr(4'h3, 4'd1, 4'd2, 4'h0), enc_ri(4'h8, 4'h9, 8'h01),
			enc_ri(4'hE, 4'd10, 8'd1), enc_ri(4'hE, 4'd11, 8'd1),
			enc_ri(4'h7, 4'd4, 8'd1), enc_ri(4'h8, 4'hB, 8'h01),
			enc_ri(4'h7, 4'd4, 8'd1), enc_ri(4'h7, 4'd4, 8'd1),
			enc_rr(4'h3, 4'd1, 4'd3, 4'h0), enc_ri(4'h8, 4'hB, 8'h01),
			enc_ri(4'hE, 4'd12, 8'd1), enc_ri(4'hE, 4'd13, 8'd1),
			enc_ri(4'h7, 4'd4, 8'd1), enc_ri(4'h8, 4'h9, 8'h01),
			enc_ri(4'h7, 4'd4, 8'd1), enc_ri(4'h7, 4'd4, 8'd1)};
		load_and_reset();
		wait_drain();
		// Six increments run, both taken branches land on one
		check_reg("branch count", 4, 32'd6);
		for (int i = 10; i < 14; i++) begin
			check_reg("branch marker", i, '0);
		end
		check_eq("branch t", '0, word_t'(t_bit));
	endtask

	task automatic test_en_freeze();
		word_t held_addr;
		word_t r1;
		word_t r2;
		logic  t_exp;
		code = '{enc_ri(4'hE, 4'd1, 8'h35), enc_ri(4'h7, 4'd1, 8'hF0),
			enc_rr(4'h3, 4'd2, 4'd1, 4'hC), enc_rr(4'h2, 4'd2, 4'd1, 4'hA),
			enc_ri(4'h4, 4'd2, 8'h00), enc_rr(4'h3, 4'd3, 4'd2, 4'h8),
			enc_rr(4'h3, 4'd3, 4'd1, 4'h0), enc_ri(4'h4, 4'd1, 8'h01)};
		// Final state of the program, SHLR of R1 sets T last
		r1 = sext8(8'h35) + sext8(8'hF0);
		r2 = (32'd0 + r1) ^ r1;
		r2 = r2 << 1;
		t_exp = r1[0];
		for (int i = 0; i < 16; i++) begin
			exp_regs[i] = '0;
		end
		exp_regs[1] = r1 >> 1;
		exp_regs[2] = r2;
		exp_regs[3] = 32'd0 - r2;
		load_and_reset();
		wait_drain();
		check_state("no freeze", t_exp);
		load_and_reset();
		repeat (2 + $urandom % 5) @(posedge CLK);
		en <= 1'b0;
		@(negedge CLK);
		held_addr = inst_addr;
		for (int i = 0; i < 16; i++) begin
			read_reg(reg_idx_t'(i), regs_b[i]);
		end
		repeat (1 + $urandom % 8) begin
			@(negedge CLK);
			check_eq("freeze pc", held_addr, inst_addr);
		end
		for (int i = 0; i < 16; i++) begin
			check_reg("freeze hold", i, regs_b[i]);
		end
		check_eq("freeze pc", held_addr, inst_addr);
		@(posedge CLK);
		en <= 1'b1;
		wait_drain();
		check_state("freeze result", t_exp);
	endtask

	initial begin
		void'($urandom(75));
		RST_N    = 1'b0;
		en       = 1'b0;
		dbg_regn = '0;
		test_reset_state();
		test_forwarding();
		test_logic_shift();
		test_branches();
		test_en_freeze();
		asserts = i_sh_core.i_assertions.fail_count;
		$display("mismatches: %0d, assertion failures: %0d", mismatches, asserts);
		if (mismatches == 0 && asserts == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

/* project.f */
src/sh_pkg.sv
src/sh_fetch.sv
src/sh_decode.sv
src/sh_regfile.sv
src/sh_execute.sv
src/sh_core.sv
tests/sh_core_assertions.sv
tests/tb_sh_core.sv
